//--- Makefile
# Verilator build and run of the arcade shell testbench.
# Any variable can be overridden, for example: make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_arcade_shell
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SOURCES   := $(wildcard logic/*.sv logic/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
+incdir+logic
logic/arcade_pkg.sv
logic/host_link.sv
logic/control_mapper.sv
logic/video_blank_expand.sv
logic/video_blend.sv
logic/video_scanline.sv
logic/audio_dac.sv
logic/arcade_shell.sv
verification/tb_arcade_shell.sv

//--- logic/arcade_defs.svh
// Fixed widths of the arcade board shell.
// Include this header wherever colour, audio or host widths are needed.

`ifndef ARCADE_DEFS_SVH
`define ARCADE_DEFS_SVH

// Colour depth per channel as the game core produces it
`define ARCADE_COLOR_IN_W 2

// Colour depth per channel on the VGA connector
`define ARCADE_COLOR_OUT_W 6

// Game audio sample width, unsigned
`define ARCADE_AUDIO_W 9

// One host transfer word
`define ARCADE_HOST_W 32

`endif

//--- logic/arcade_pkg.sv
// Shared types of the arcade shell: host words, controls and video samples.
// Modules import this package in their bodies and use scoped names in ports.

`include "arcade_defs.svh"

package arcade_pkg;

	// ====================================================================
	// Host words
	// ====================================================================

	// Bit positions follow the core's option string: T0 reset, O2 rotate,
	// O34 scanlines and O5 blend
	typedef struct packed {
		logic [`ARCADE_HOST_W-7:0] spare_hi;
		logic                      blend;
		logic [1:0]                scanlines;
		logic                      rotate;
		logic                      spare_lo;
		logic                      soft_reset;
	} settings_t;

	// One player's stick and buttons, right in bit 0
	typedef struct packed {
		logic start;
		logic coin;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef struct packed {
		logic [`ARCADE_HOST_W-17:0] spare;
		joy_t                       player2;
		joy_t                       player1;
	} joy_pair_t;

	// The same host word is read as settings (host_sel 0) or joysticks (host_sel 1)
	typedef union packed {
		settings_t settings;
		joy_pair_t joys;
	} host_word_u;

	// ====================================================================
	// Video and controls
	// ====================================================================

	typedef struct packed {
		logic                          ce;
		logic                          hs;
		logic                          vs;
		logic                          hb;
		logic                          vb;
		logic [`ARCADE_COLOR_IN_W-1:0] r;
		logic [`ARCADE_COLOR_IN_W-1:0] g;
		logic [`ARCADE_COLOR_IN_W-1:0] b;
	} pixel_t;

	typedef struct packed {
		logic                           ce;
		logic                           hs;
		logic                           vs;
		logic                           hb;
		logic                           vb;
		logic [`ARCADE_COLOR_OUT_W-1:0] r;
		logic [`ARCADE_COLOR_OUT_W-1:0] g;
		logic [`ARCADE_COLOR_OUT_W-1:0] b;
	} pixel_out_t;

	// Active-low pairs, player 2 in bit 1 and player 1 in bit 0
	typedef struct packed {
		logic [1:0] coin;
		logic [1:0] start;
		logic [1:0] fire;
		logic [1:0] bomb;
		logic [1:0] up;
		logic [1:0] down;
		logic [1:0] left;
		logic [1:0] right;
		logic [1:0] tilt;
	} buttons_t;

endpackage

//--- logic/arcade_shell.sv
// Board shell around the arcade game core.
// Connects the host link, control mapping, three-stage video path and audio DAC.
// The core itself and the host controller sit outside this module.

`timescale 1ns/1ns

`include "arcade_defs.svh"

module arcade_shell (
	input  logic                            clk_sys,
	input  logic                            arst_n,
	input  logic                            host_req,
	input  logic                            host_sel,
	input  arcade_pkg::host_word_u          host_data,
	output logic                            host_ack,
	input  logic                            reset_button,
	input  arcade_pkg::pixel_t              core_pix,
	input  logic [`ARCADE_AUDIO_W-1:0]      core_audio,
	output arcade_pkg::buttons_t            buttons,
	output logic                            game_reset,
	output logic [`ARCADE_COLOR_OUT_W-1:0]  vga_r,
	output logic [`ARCADE_COLOR_OUT_W-1:0]  vga_g,
	output logic [`ARCADE_COLOR_OUT_W-1:0]  vga_b,
	output logic                            vga_hs,
	output logic                            vga_vs,
	output logic                            audio_l,
	output logic                            audio_r,
	output logic                            led
);

	import arcade_pkg::*;

	settings_t  settings;
	joy_pair_t  joys;
	pixel_out_t pix_expanded;
	pixel_out_t pix_blended;

	// The board LED stays lit while the core is loaded
	assign led     = 1'b1;
	// Mono game, both channels carry the same stream
	assign audio_r = audio_l;

	host_link u_host_link (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.host_req  (host_req),
		.host_sel  (host_sel),
		.host_data (host_data),
		.host_ack  (host_ack),
		.settings  (settings),
		.joys      (joys)
	);

	control_mapper u_control_mapper (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.joys         (joys),
		.rotate       (settings.rotate),
		.reset_button (reset_button),
		.soft_reset   (settings.soft_reset),
		.buttons      (buttons),
		.game_reset   (game_reset)
	);

	// ====================================================================
	// Video path, three registers from core to VGA pins
	// ====================================================================

	video_blank_expand u_video_blank_expand (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.pix_in  (core_pix),
		.pix_out (pix_expanded)
	);

	video_blend u_video_blend (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.blend   (settings.blend),
		.pix_in  (pix_expanded),
		.pix_out (pix_blended)
	);

	video_scanline u_video_scanline (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.scanlines (settings.scanlines),
		.pix_in    (pix_blended),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

	audio_dac u_audio_dac (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.sample  (core_audio),
		.dac_out (audio_l)
	);

endmodule

//--- logic/audio_dac.sv
// First-order sigma-delta DAC for the unsigned game audio.
// The 1-bit output feeds an RC filter on the board's audio pins.

`timescale 1ns/1ns

`include "arcade_defs.svh"

module audio_dac (
	input  logic                       clk_sys,
	input  logic                       arst_n,
	input  logic [`ARCADE_AUDIO_W-1:0] sample,
	output logic                       dac_out
);

	logic [`ARCADE_AUDIO_W-1:0] acc;
	logic [`ARCADE_AUDIO_W:0]   sum;

	// The carry out of the accumulator is the pulse density
	assign sum = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[`ARCADE_AUDIO_W-1:0];
			dac_out <= sum[`ARCADE_AUDIO_W];
		end
	end

endmodule

//--- logic/control_mapper.sv
// Turns the host's joystick state into the core's active-low button pairs.
// Optional 90-degree rotation for vertical cabinets, plus the game reset.

`timescale 1ns/1ns

module control_mapper (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  arcade_pkg::joy_pair_t joys,
	input  logic                  rotate,
	input  logic                  reset_button,
	input  logic                  soft_reset,
	output arcade_pkg::buttons_t  buttons,
	output logic                  game_reset
);

	import arcade_pkg::*;

	joy_t p1;
	joy_t p2;

	// Rotated stick: up from left, right from up, down from right, left from down
	function automatic joy_t turn(input joy_t j, input logic rot);
		joy_t t;
		t = j;
		if (rot) begin
			t.up    = j.left;
			t.right = j.up;
			t.down  = j.right;
			t.left  = j.down;
		end
		return t;
	endfunction

	assign p1 = turn(joys.player1, rotate);
	assign p2 = turn(joys.player2, rotate);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			// Everything released
			buttons    <= '1;
			game_reset <= 1'b0;
		end else begin
			buttons.coin  <= ~{p2.coin, p1.coin};
			buttons.start <= ~{p2.start, p1.start};
			buttons.fire  <= ~{p2.fire_a, p1.fire_a};
			buttons.bomb  <= ~{p2.fire_b, p1.fire_b};
			buttons.up    <= ~{p2.up, p1.up};
			buttons.down  <= ~{p2.down, p1.down};
			buttons.left  <= ~{p2.left, p1.left};
			buttons.right <= ~{p2.right, p1.right};
			// No tilt switch on this board
			buttons.tilt  <= 2'b11;
			game_reset    <= soft_reset || reset_button;
		end
	end

endmodule

//--- logic/host_link.sv
// Receiver for the host controller's four-phase req/ack link.
// Each transfer carries one word, stored as settings or joystick state
// depending on host_sel.

`timescale 1ns/1ns

module host_link (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   host_req,
	input  logic                   host_sel,
	input  arcade_pkg::host_word_u host_data,
	output logic                   host_ack,
	output arcade_pkg::settings_t  settings,
	output arcade_pkg::joy_pair_t  joys
);

	import arcade_pkg::*;

	// Set for one cycle once req has been seen low while ack is still high
	logic release_seen;
	logic take_word;

	// A new word is accepted only when the previous handshake has closed
	assign take_word = host_req && !host_ack;

	// ====================================================================
	// Handshake
	// ====================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			host_ack     <= 1'b0;
			release_seen <= 1'b0;
		end else begin
			release_seen <= host_ack && !host_req && !release_seen;
			if (take_word) begin
				host_ack <= 1'b1;
			end else if (release_seen) begin
				// Drop ack the cycle after the host's release was sampled
				host_ack <= 1'b0;
			end
		end
	end

	// ====================================================================
	// Word decode
	// ====================================================================

	// Only the register selected by host_sel is written
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			settings <= '0;
			joys     <= '0;
		end else if (take_word) begin
			if (host_sel) begin
				joys <= host_data.joys;
			end else begin
				settings <= host_data.settings;
			end
		end
	end

endmodule

//--- logic/video_blank_expand.sv
// Video stage 1: blanks the core colour and widens it to VGA depth.
// One register, so the sample leaves one clock after it enters.

`timescale 1ns/1ns

`include "arcade_defs.svh"

module video_blank_expand (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  arcade_pkg::pixel_t     pix_in,
	output arcade_pkg::pixel_out_t pix_out
);

	import arcade_pkg::*;

	localparam int REP = `ARCADE_COLOR_OUT_W / `ARCADE_COLOR_IN_W;

	logic       blank;
	pixel_out_t expanded;

	assign blank = pix_in.hb || pix_in.vb;

	// Repeating the bits maps full scale onto full scale (3 -> 63)
	always_comb begin
		expanded.ce = pix_in.ce;
		expanded.hs = pix_in.hs;
		expanded.vs = pix_in.vs;
		expanded.hb = pix_in.hb;
		expanded.vb = pix_in.vb;
		expanded.r  = blank ? '0 : {REP{pix_in.r}};
		expanded.g  = blank ? '0 : {REP{pix_in.g}};
		expanded.b  = blank ? '0 : {REP{pix_in.b}};
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			pix_out <= '0;
		end else begin
			pix_out <= expanded;
		end
	end

endmodule

//--- logic/video_blend.sv
// Video stage 2: optional horizontal blend that softens the core's pixels.
// Each ce sample can be averaged with the previous ce sample of its line.

`timescale 1ns/1ns

`include "arcade_defs.svh"

module video_blend (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   blend,
	input  arcade_pkg::pixel_out_t pix_in,
	output arcade_pkg::pixel_out_t pix_out
);

	import arcade_pkg::*;

	localparam int W = `ARCADE_COLOR_OUT_W;

	// Colour of the last ce sample seen on this line
	logic [W-1:0] hist_r;
	logic [W-1:0] hist_g;
	logic [W-1:0] hist_b;
	pixel_out_t   mixed;

	function automatic logic [W-1:0] avg(input logic [W-1:0] a, input logic [W-1:0] b);
		logic [W:0] sum;
		sum = {1'b0, a} + {1'b0, b};
		return sum[W:1];
	endfunction

	// Blanked samples stay black, so only active ce samples are mixed
	always_comb begin
		mixed = pix_in;
		if (blend && pix_in.ce && !pix_in.hb) begin
			mixed.r = avg(pix_in.r, hist_r);
			mixed.g = avg(pix_in.g, hist_g);
			mixed.b = avg(pix_in.b, hist_b);
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			pix_out <= '0;
			hist_r  <= '0;
			hist_g  <= '0;
			hist_b  <= '0;
		end else begin
			pix_out <= mixed;
			if (pix_in.hb) begin
				// A new line starts from black
				hist_r <= '0;
				hist_g <= '0;
				hist_b <= '0;
			end else if (pix_in.ce) begin
				hist_r <= pix_in.r;
				hist_g <= pix_in.g;
				hist_b <= pix_in.b;
			end
		end
	end

endmodule

//--- logic/video_scanline.sv
// Video stage 3: scanline effect and the registered VGA outputs.
// Odd lines are dimmed by the amount picked in the settings word.

`timescale 1ns/1ns

`include "arcade_defs.svh"

module video_scanline (
	input  logic                            clk_sys,
	input  logic                            arst_n,
	input  logic [1:0]                      scanlines,
	input  arcade_pkg::pixel_out_t          pix_in,
	output logic [`ARCADE_COLOR_OUT_W-1:0]  vga_r,
	output logic [`ARCADE_COLOR_OUT_W-1:0]  vga_g,
	output logic [`ARCADE_COLOR_OUT_W-1:0]  vga_b,
	output logic                            vga_hs,
	output logic                            vga_vs
);

	localparam int W = `ARCADE_COLOR_OUT_W;

	logic hs_d;
	logic odd_line;

	// 0 off, 1 keeps three quarters, 2 keeps half, 3 keeps a quarter
	function automatic logic [W-1:0] dim(input logic [W-1:0] v, input logic [1:0] sel);
		logic [W-1:0] q;
		q = v >> 2;
		case (sel)
			2'd1:    return v - q;
			2'd2:    return v >> 1;
			2'd3:    return q;
			default: return v;
		endcase
	endfunction

	// ====================================================================
	// Line parity
	// ====================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			hs_d     <= 1'b0;
			odd_line <= 1'b0;
		end else begin
			hs_d <= pix_in.hs;
			if (pix_in.vs) begin
				odd_line <= 1'b0;
			end else if (pix_in.hs && !hs_d) begin
				odd_line <= !odd_line;
			end
		end
	end

	// ====================================================================
	// VGA outputs
	// ====================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			vga_r  <= odd_line ? dim(pix_in.r, scanlines) : pix_in.r;
			vga_g  <= odd_line ? dim(pix_in.g, scanlines) : pix_in.g;
			vga_b  <= odd_line ? dim(pix_in.b, scanlines) : pix_in.b;
			vga_hs <= pix_in.hs;
			vga_vs <= pix_in.vs;
		end
	end

endmodule

//--- verification/tb_arcade_shell.sv
// Random-stimulus testbench for the arcade board shell.
// It plays the host controller and the game core, and checks the DUT against
// its own models of the control mapping, the video pipeline and the audio DAC.

`timescale 1ns/1ns

`include "arcade_defs.svh"

module tb_arcade_shell;

	import arcade_pkg::*;

	localparam int W          = `ARCADE_COLOR_OUT_W;
	localparam int AW         = `ARCADE_AUDIO_W;
	// About twice the summed length of all tests
	localparam int MAX_CYCLES = 20000;
	localparam int ACK_WAIT   = 20;
	localparam int ACTIVE     = 64;
	localparam int BLANKED    = 8;
	localparam int LINES      = 6;
	localparam int VS_LINES   = 2;

	logic          clk_sys = 1'b0;
	logic          arst_n;
	logic          host_req;
	logic          host_sel;
	host_word_u    host_data;
	logic          host_ack;
	logic          reset_button;
	pixel_t        core_pix;
	logic [AW-1:0] core_audio;
	buttons_t      buttons;
	logic          game_reset;
	logic [W-1:0]  vga_r;
	logic [W-1:0]  vga_g;
	logic [W-1:0]  vga_b;
	logic          vga_hs;
	logic          vga_vs;
	logic          audio_l;
	logic          audio_r;
	logic          led;

	integer    seed;
	int        cycles         = 0;
	int        link_errors    = 0;
	int        control_errors = 0;
	int        video_errors   = 0;
	int        audio_errors   = 0;
	settings_t exp_set;
	joy_pair_t exp_joys;
	logic      video_on;

	// Video model state and the three-deep prediction line
	pixel_out_t   pred_q [3];
	logic [2:0]   pred_ok;
	logic [W-1:0] m_hist_r;
	logic [W-1:0] m_hist_g;
	logic [W-1:0] m_hist_b;
	logic         m_hs_d;
	logic         m_odd;

	arcade_shell u_arcade_shell (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.host_req     (host_req),
		.host_sel     (host_sel),
		.host_data    (host_data),
		.host_ack     (host_ack),
		.reset_button (reset_button),
		.core_pix     (core_pix),
		.core_audio   (core_audio),
		.buttons      (buttons),
		.game_reset   (game_reset),
		.vga_r        (vga_r),
		.vga_g        (vga_g),
		.vga_b        (vga_b),
		.vga_hs       (vga_hs),
		.vga_vs       (vga_vs),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.led          (led)
	);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ====================================================================
	// Reference rules
	// ====================================================================

	// Returns 1 and prints an error line when the values differ
	function automatic int mismatch(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		int bad;
		bad = 0;
		assert (act_v === exp_v) else begin
			$display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp_v, act_v);
			bad = 1;
		end
		return bad;
	endfunction

	// 2-bit levels 0..3 land on 0, 21, 42 and 63
	function automatic logic [W-1:0] widen(input logic [1:0] v, input logic blank);
		int x;
		x = blank ? 0 : 21 * int'(v);
		return x[W-1:0];
	endfunction

	function automatic logic [W-1:0] mix(input logic [W-1:0] a, input logic [W-1:0] b);
		int s;
		s = (int'(a) + int'(b)) / 2;
		return s[W-1:0];
	endfunction

	function automatic logic [W-1:0] scan_dim(input logic [W-1:0] v, input logic [1:0] sel);
		int x;
		int q;
		x = int'(v);
		q = x / 4;
		case (sel)
			2'd1:    x = x - q;
			2'd2:    x = x / 2;
			2'd3:    x = q;
			default: x = x;
		endcase
		return x[W-1:0];
	endfunction

	function automatic buttons_t expected_buttons(input joy_pair_t j, input logic rot);
		buttons_t b;
		joy_t     p [2];
		p[0] = j.player1;
		p[1] = j.player2;
		for (int i = 0; i < 2; i++) begin
			b.coin[i]  = !p[i].coin;
			b.start[i] = !p[i].start;
			b.fire[i]  = !p[i].fire_a;
			b.bomb[i]  = !p[i].fire_b;
			b.tilt[i]  = 1'b1;
			if (rot) begin
				b.up[i]    = !p[i].left;
				b.right[i] = !p[i].up;
				b.down[i]  = !p[i].right;
				b.left[i]  = !p[i].down;
			end else begin
				b.up[i]    = !p[i].up;
				b.right[i] = !p[i].right;
				b.down[i]  = !p[i].down;
				b.left[i]  = !p[i].left;
			end
		end
		return b;
	endfunction

	// ====================================================================
	// Video model, sampled on the falling edge
	// ====================================================================

	// A sample seen here enters the DUT on the next rising edge, so its VGA
	// result is visible three falling edges later
	always @(negedge clk_sys) begin : video_model
		pixel_out_t s1;
		pixel_out_t s2;
		pixel_out_t s3;
		if (!arst_n) begin
			pred_ok  = '0;
			m_hist_r = '0;
			m_hist_g = '0;
			m_hist_b = '0;
			m_hs_d   = 1'b0;
			m_odd    = 1'b0;
		end else begin
			if (pred_ok[2]) begin
				video_errors += mismatch("vga_r", 32'(pred_q[2].r), 32'(vga_r));
				video_errors += mismatch("vga_g", 32'(pred_q[2].g), 32'(vga_g));
				video_errors += mismatch("vga_b", 32'(pred_q[2].b), 32'(vga_b));
				video_errors += mismatch("vga_hs", 32'(pred_q[2].hs), 32'(vga_hs));
				video_errors += mismatch("vga_vs", 32'(pred_q[2].vs), 32'(vga_vs));
			end
			s1.ce = core_pix.ce;
			s1.hs = core_pix.hs;
			s1.vs = core_pix.vs;
			s1.hb = core_pix.hb;
			s1.vb = core_pix.vb;
			s1.r  = widen(core_pix.r, core_pix.hb | core_pix.vb);
			s1.g  = widen(core_pix.g, core_pix.hb | core_pix.vb);
			s1.b  = widen(core_pix.b, core_pix.hb | core_pix.vb);
			s2 = s1;
			if (exp_set.blend && s1.ce && !s1.hb) begin
				s2.r = mix(s1.r, m_hist_r);
				s2.g = mix(s1.g, m_hist_g);
				s2.b = mix(s1.b, m_hist_b);
			end
			if (s1.hb) begin
				m_hist_r = '0;
				m_hist_g = '0;
				m_hist_b = '0;
			end else if (s1.ce) begin
				m_hist_r = s1.r;
				m_hist_g = s1.g;
				m_hist_b = s1.b;
			end
			// The parity in force for this sample comes from earlier samples only
			s3 = s2;
			if (m_odd) begin
				s3.r = scan_dim(s2.r, exp_set.scanlines);
				s3.g = scan_dim(s2.g, exp_set.scanlines);
				s3.b = scan_dim(s2.b, exp_set.scanlines);
			end
			if (s2.vs) begin
				m_odd = 1'b0;
			end else if (s2.hs && !m_hs_d) begin
				m_odd = !m_odd;
			end
			m_hs_d    = s2.hs;
			pred_q[2] = pred_q[1];
			pred_q[1] = pred_q[0];
			pred_q[0] = s3;
			pred_ok   = {pred_ok[1:0], video_on};
		end
	end

	// ====================================================================
	// Stimulus tasks
	// ====================================================================

	task automatic idle(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic check_controls;
		buttons_t expected;
		expected = expected_buttons(exp_joys, exp_set.rotate);
		control_errors += mismatch("buttons", 32'(expected), 32'(buttons));
		control_errors += mismatch("game_reset", 32'(exp_set.soft_reset | reset_button),
			32'(game_reset));
	endtask

	// One four-phase transfer, with the control outputs checked on the
	// second cycle after ack rises
	task automatic host_write(input logic sel, input host_word_u word);
		int n;
		@(posedge clk_sys);
		host_sel  <= sel;
		host_data <= word;
		host_req  <= 1'b1;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (host_ack !== 1'b1 && n < ACK_WAIT);
		assert (host_ack === 1'b1) else begin
			$display("Handshake failure: host_ack did not rise within %0d cycles", ACK_WAIT);
			link_errors++;
		end
		if (sel) begin
			exp_joys = word.joys;
		end else begin
			exp_set = word.settings;
		end
		@(posedge clk_sys);
		host_req <= 1'b0;
		@(negedge clk_sys);
		// The word was latched with ack, the buttons follow one cycle later
		check_controls();
		n = 1;
		while (host_ack !== 1'b0 && n < ACK_WAIT) begin
			@(negedge clk_sys);
			n++;
		end
		assert (host_ack === 1'b0) else begin
			$display("Handshake failure: host_ack did not fall within %0d cycles", ACK_WAIT);
			link_errors++;
		end
	endtask

	task automatic write_settings(input logic blend, input logic [1:0] scanlines,
		input logic rotate, input logic soft_reset);
		host_word_u word;
		word                     = '0;
		word.settings.blend      = blend;
		word.settings.scanlines  = scanlines;
		word.settings.rotate     = rotate;
		word.settings.soft_reset = soft_reset;
		host_write(1'b0, word);
	endtask

	task automatic joystick_writes(input int n);
		host_word_u word;
		logic [31:0] r;
		repeat (n) begin
			r    = $random(seed);
			word = r;
			host_write(1'b1, word);
		end
	endtask

	// Six visible lines, then two lines of vertical sync
	task automatic run_frame;
		pixel_t      p;
		logic [31:0] r;
		for (int line = 0; line < LINES + VS_LINES; line++) begin
			for (int x = 0; x < ACTIVE + BLANKED; x++) begin
				r    = $random(seed);
				p.ce = r[0] | r[7];
				p.r  = r[2:1];
				p.g  = r[4:3];
				p.b  = r[6:5];
				p.hb = (x >= ACTIVE);
				p.hs = (x >= ACTIVE);
				p.vb = (line >= LINES);
				p.vs = (line >= LINES);
				@(posedge clk_sys);
				video_on  = 1'b1;
				core_pix <= p;
			end
		end
		@(posedge clk_sys);
		video_on = 1'b0;
		// Let the last predictions leave the pipeline
		idle(4);
	endtask

	task automatic run_audio(input logic [AW-1:0] s);
		int ones;
		ones = 0;
		@(posedge clk_sys);
		core_audio <= s;
		for (int i = 0; i < 1024; i++) begin
			@(negedge clk_sys);
			if (i >= 512) begin
				ones += int'(audio_l);
			end
			audio_errors += mismatch("audio_r", 32'(audio_l), 32'(audio_r));
		end
		audio_errors += mismatch("audio_l ones", 32'(s), ones);
	endtask

	// ====================================================================
	// Test sequence
	// ====================================================================

	initial begin
		buttons_t    released;
		host_word_u  word;
		logic [31:0] r;
		seed         = 32'he5d0;
		released     = '1;
		exp_set      = '0;
		exp_joys     = '0;
		video_on     = 1'b0;
		arst_n       = 1'b0;
		host_req     = 1'b0;
		host_sel     = 1'b0;
		host_data    = '0;
		reset_button = 1'b0;
		core_pix     = '0;
		core_audio   = '0;
		repeat (3) @(posedge clk_sys);
		arst_n <= 1'b1;
		@(negedge clk_sys);

		control_errors += mismatch("host_ack", 32'd0, 32'(host_ack));
		control_errors += mismatch("game_reset", 32'd0, 32'(game_reset));
		control_errors += mismatch("buttons", 32'(released), 32'(buttons));
		control_errors += mismatch("vga_r", 32'd0, 32'(vga_r));
		control_errors += mismatch("vga_g", 32'd0, 32'(vga_g));
		control_errors += mismatch("vga_b", 32'd0, 32'(vga_b));
		control_errors += mismatch("vga_hs", 32'd0, 32'(vga_hs));
		control_errors += mismatch("vga_vs", 32'd0, 32'(vga_vs));
		// The board expects the LED lit
		control_errors += mismatch("led", 32'd1, 32'(led));

		// Mixed settings and joystick words
		repeat (20) begin
			r    = $random(seed);
			word = $random(seed);
			host_write(r[0], word);
		end

		// Mapping with and without rotation, then both reset sources
		write_settings(1'b0, 2'd0, 1'b0, 1'b0);
		joystick_writes(8);
		write_settings(1'b0, 2'd0, 1'b1, 1'b0);
		joystick_writes(8);
		write_settings(1'b0, 2'd0, 1'b0, 1'b1);
		write_settings(1'b0, 2'd0, 1'b0, 1'b0);
		@(posedge clk_sys);
		reset_button <= 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_controls();
		@(posedge clk_sys);
		reset_button <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_controls();

		// Plain video, blended video, then each scanline depth
		run_frame();
		write_settings(1'b1, 2'd0, 1'b0, 1'b0);
		run_frame();
		for (int sl = 1; sl < 4; sl++) begin
			write_settings(1'b0, 2'(sl), 1'b0, 1'b0);
			run_frame();
		end

		repeat (5) begin
			r = $random(seed);
			run_audio(r[AW-1:0]);
		end

		$display("Error counts: link %0d, controls %0d, video %0d, audio %0d",
			link_errors, control_errors, video_errors, audio_errors);
		if (link_errors + control_errors + video_errors + audio_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
